//--- design/blockSequencer.sv
`default_nettype none

module blockSequencer (
	input wire clock,
	input wire reset,
	input wire start,
	input wire [minerPkg::headerBits-1:0] header,
	input wire [minerPkg::nonceBits-1:0] startNonce,
	input wire [minerPkg::nonceBits-1:0] nonceCount,
	output logic busy,
	output logic done,
	output logic coreLoad,
	output logic [minerPkg::blockBits-1:0] coreBlock,
	output logic [minerPkg::digestBits-1:0] coreChain,
	input wire coreBusy,
	input wire digestValid,
	input wire [minerPkg::digestBits-1:0] digest,
	output logic hashValid,
	output logic [minerPkg::nonceBits-1:0] hashNonce,
	input wire hit,
	input wire miss
);

	logic [minerPkg::stateBits-1:0] state;
	logic issued; // a block of this state is in the core
	logic taken;
	logic inJob;
	logic [minerPkg::headerBits-minerPkg::nonceBits-1:0] headerReg; // nonce field dropped
	logic [minerPkg::nonceBits-1:0] nonce, remaining;
	logic [minerPkg::nonceBits-1:0] swappedNonce;
	logic [minerPkg::digestBits-1:0] midstate, firstDigest;

	assign busy = state != minerPkg::stateIdle;
	assign inJob = state == minerPkg::stateFirst || state == minerPkg::stateSecond
		|| state == minerPkg::stateFinal;
	assign coreLoad = inJob && !issued && !coreBusy;
	// digests of blocks orphaned by a hit arrive with issued low
	assign taken = issued && digestValid;
	assign hashValid = taken && state == minerPkg::stateFinal;
	assign hashNonce = nonce;
	assign swappedNonce = {<<8{nonce}}; // little-endian in the header

	always_comb begin
		case (state)
			minerPkg::stateSecond:
				coreBlock = {headerReg[95:0], swappedNonce, minerPkg::tailTwoPad};
			minerPkg::stateFinal:
				coreBlock = {firstDigest, minerPkg::finalPad};
			default:
				coreBlock = headerReg[607:96];
		endcase
	end

	assign coreChain = state == minerPkg::stateSecond ? midstate : shaPkg::initHash;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= minerPkg::stateIdle;
			issued <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (coreLoad)
				issued <= 1'b1;
			if (taken)
				issued <= 1'b0;
			case (state)
				minerPkg::stateIdle:
					if (start)
						state <= minerPkg::stateFirst;
				minerPkg::stateFirst:
					if (taken)
						state <= minerPkg::stateSecond;
				minerPkg::stateSecond:
					if (hit) begin // verdict on the previous nonce
						state <= minerPkg::stateIdle;
						issued <= 1'b0;
						done <= 1'b1;
					end else if (taken) begin
						state <= minerPkg::stateFinal;
					end
				minerPkg::stateFinal:
					if (taken)
						state <= remaining == 1 ? minerPkg::stateDrain : minerPkg::stateSecond;
				minerPkg::stateDrain:
					if (hit || miss) begin
						state <= minerPkg::stateIdle;
						done <= 1'b1;
					end
				default:
					state <= minerPkg::stateIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == minerPkg::stateIdle && start) begin
			headerReg <= header[minerPkg::headerBits-1:minerPkg::nonceBits];
			nonce <= startNonce;
			remaining <= nonceCount; // zero runs the whole nonce space
		end
		if (taken && state == minerPkg::stateFirst)
			midstate <= digest;
		if (taken && state == minerPkg::stateSecond)
			firstDigest <= digest;
		if (hashValid && remaining != 1) begin
			nonce <= nonce + 1'b1;
			remaining <= remaining - 1'b1;
		end
	end

	doneDuringLoad: assert property (@(posedge clock) disable iff (reset) !(done && coreLoad))
		else $error("done raised while a block is being loaded");

endmodule

`default_nettype wire

//--- design/minerPkg.sv
`default_nettype none

package minerPkg;

	localparam int headerBits = 640;
	localparam int blockBits = 512;
	localparam int digestBits = 256;
	localparam int nonceBits = 32;

	// one bit, zeros, then the 64-bit message length
	localparam logic [383:0] tailTwoPad = {1'b1, 319'b0, 64'd640};
	localparam logic [255:0] finalPad = {1'b1, 191'b0, 64'd256};

	// job states of the block sequencer
	localparam int stateBits = 3;
	localparam logic [stateBits-1:0] stateIdle = 3'd0;
	localparam logic [stateBits-1:0] stateFirst = 3'd1;
	localparam logic [stateBits-1:0] stateSecond = 3'd2;
	localparam logic [stateBits-1:0] stateFinal = 3'd3;
	localparam logic [stateBits-1:0] stateDrain = 3'd4;

endpackage

`default_nettype wire

//--- design/minerTop.sv
`default_nettype none

module minerTop (
	input wire clock,
	input wire reset,
	input wire start,
	input wire [minerPkg::headerBits-1:0] header,
	input wire [minerPkg::nonceBits-1:0] startNonce,
	input wire [minerPkg::nonceBits-1:0] nonceCount,
	input wire [minerPkg::digestBits-1:0] target,
	output logic busy,
	output logic done,
	output logic found,
	output logic [minerPkg::nonceBits-1:0] foundNonce,
	output logic [minerPkg::digestBits-1:0] foundHash
);

	logic coreLoad, coreBusy, digestValid;
	logic [minerPkg::blockBits-1:0] coreBlock;
	logic [minerPkg::digestBits-1:0] coreChain, digest;
	logic hashValid, hit, miss;
	logic [minerPkg::nonceBits-1:0] hashNonce;
	logic startAccept;

	assign startAccept = start && !busy; // starts during a job are dropped

	blockSequencer i_sequencer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.header(header),
		.startNonce(startNonce),
		.nonceCount(nonceCount),
		.busy(busy),
		.done(done),
		.coreLoad(coreLoad),
		.coreBlock(coreBlock),
		.coreChain(coreChain),
		.coreBusy(coreBusy),
		.digestValid(digestValid),
		.digest(digest),
		.hashValid(hashValid),
		.hashNonce(hashNonce),
		.hit(hit),
		.miss(miss)
	);

	sha256Core i_core (
		.clock(clock),
		.reset(reset),
		.load(coreLoad),
		.block(coreBlock),
		.chainIn(coreChain),
		.busy(coreBusy),
		.digestValid(digestValid),
		.digestOut(digest)
	);

	targetCheck i_check (
		.clock(clock),
		.reset(reset),
		.start(startAccept),
		.target(target),
		.hashValid(hashValid),
		.hashNonce(hashNonce),
		.digest(digest),
		.hit(hit),
		.miss(miss),
		.found(found),
		.foundNonce(foundNonce),
		.foundHash(foundHash)
	);

endmodule

`default_nettype wire

//--- design/sha256Core.sv
`default_nettype none

module sha256Core (
	input wire clock,
	input wire reset,
	input wire load,
	input wire [minerPkg::blockBits-1:0] block,
	input wire [minerPkg::digestBits-1:0] chainIn,
	output logic busy,
	output logic digestValid,
	output logic [minerPkg::digestBits-1:0] digestOut
);

	logic [31:0] a, b, c, d, e, f, g, h;
	logic [31:0] w [16]; // w[0] is the current round word
	logic [minerPkg::digestBits-1:0] chain;
	logic [$clog2(shaPkg::rounds)-1:0] roundCount;
	logic [31:0] t1, t2, nextW;

	function automatic logic [31:0] ror(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	always_comb begin
		t1 = h + (ror(e, 6) ^ ror(e, 11) ^ ror(e, 25)) + ((e & f) ^ (~e & g))
			+ shaPkg::roundK[roundCount] + w[0];
		t2 = (ror(a, 2) ^ ror(a, 13) ^ ror(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
		// W[t+16] from the window
		nextW = (ror(w[14], 17) ^ ror(w[14], 19) ^ (w[14] >> 10)) + w[9]
			+ (ror(w[1], 7) ^ ror(w[1], 18) ^ (w[1] >> 3)) + w[0];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			digestValid <= 1'b0;
			roundCount <= '0;
		end else begin
			digestValid <= busy && roundCount == shaPkg::rounds - 1;
			if (load) begin
				busy <= 1'b1;
				roundCount <= '0;
			end else if (busy) begin
				roundCount <= roundCount + 1'b1; // wraps to zero after the last round
				if (roundCount == shaPkg::rounds - 1)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			{a, b, c, d, e, f, g, h} <= chainIn;
			chain <= chainIn;
			for (int i = 0; i < 16; i++) begin
				w[i] <= block[minerPkg::blockBits-1-32*i -: 32];
			end
		end else if (busy) begin
			h <= g;
			g <= f;
			f <= e;
			e <= d + t1;
			d <= c;
			c <= b;
			b <= a;
			a <= t1 + t2;
			for (int i = 0; i < 15; i++) begin
				w[i] <= w[i+1];
			end
			w[15] <= nextW;
		end
	end

	// feed-forward, read in the digestValid cycle
	assign digestOut = {
		chain[255:224] + a, chain[223:192] + b, chain[191:160] + c, chain[159:128] + d,
		chain[127:96] + e, chain[95:64] + f, chain[63:32] + g, chain[31:0] + h
	};

	loadWhileBusy: assert property (@(posedge clock) disable iff (reset) !(load && busy))
		else $error("block loaded into a busy core");

endmodule

`default_nettype wire

//--- design/shaPkg.sv
`default_nettype none

package shaPkg;

	localparam int rounds = 64;

	// H0 in the top word
	localparam logic [255:0] initHash = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	localparam logic [31:0] roundK [rounds] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

endpackage

`default_nettype wire

//--- design/targetCheck.sv
`default_nettype none

module targetCheck (
	input wire clock,
	input wire reset,
	input wire start,
	input wire [minerPkg::digestBits-1:0] target,
	input wire hashValid,
	input wire [minerPkg::nonceBits-1:0] hashNonce,
	input wire [minerPkg::digestBits-1:0] digest,
	output logic hit,
	output logic miss,
	output logic found,
	output logic [minerPkg::nonceBits-1:0] foundNonce,
	output logic [minerPkg::digestBits-1:0] foundHash
);

	logic [minerPkg::digestBits-1:0] targetReg;
	logic [minerPkg::digestBits-1:0] hashValue;
	logic below;

	// digest bytes read as a little-endian number
	assign hashValue = {<<8{digest}};
	assign below = hashValue < targetReg;

	always_ff @(posedge clock) begin
		if (reset) begin
			hit <= 1'b0;
			miss <= 1'b0;
			found <= 1'b0;
		end else begin
			hit <= hashValid && below;
			miss <= hashValid && !below;
			if (hashValid && below)
				found <= 1'b1;
			else if (start)
				found <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			targetReg <= target;
		if (hashValid && below) begin
			foundNonce <= hashNonce;
			foundHash <= digest; // raw, not byte-reversed
		end
	end

	hitAndMiss: assert property (@(posedge clock) disable iff (reset) !(hit && miss))
		else $error("hit and miss raised together");

endmodule

`default_nettype wire

//--- filelist.f
design/shaPkg.sv
design/minerPkg.sv
design/sha256Core.sv
design/blockSequencer.sv
design/targetCheck.sv
design/minerTop.sv
verification/minerTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module minerTb

output=$(./obj_dir/VminerTb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Regression passed"; then
	exit 0
fi
exit 1

//--- verification/minerTb.sv
`default_nettype none

module minerTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeoutCycles = 20000; // 14 nonces at ~135 cycles plus margin

	// genesis block in serialized byte order with byte 0 on top
	localparam logic [639:0] genesisHeader = {
		32'h01000000,
		256'h0,
		256'h3ba3edfd_7a7b12b2_7ac72c3e_67768f61_7fc81bc3_888a5132_3a9fb8aa_4b1e5e4a,
		32'h29ab5f49,
		32'hffff001d,
		32'h1dac2b7c
	};
	localparam logic [31:0] knownNonce = 32'd2083236893;
	localparam logic [255:0] knownHash =
		256'h00000000_0019d668_9c085ae1_65831e93_4ff763ae_46a2a6c1_72b3f1b6_0a8ce26f;
	localparam logic [255:0] genesisTarget = {32'h0, 16'hffff, 208'h0};

	logic clock;
	logic reset;
	logic start;
	logic [639:0] header;
	logic [31:0] startNonce;
	logic [31:0] nonceCount;
	logic [255:0] target;
	wire busy;
	wire done;
	wire found;
	wire [31:0] foundNonce;
	wire [255:0] foundHash;
	int cycleCount = 0;

	minerTop i_dut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.header(header),
		.startNonce(startNonce),
		.nonceCount(nonceCount),
		.target(target),
		.busy(busy),
		.done(done),
		.found(found),
		.foundNonce(foundNonce),
		.foundHash(foundHash)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) cycleCount <= cycleCount + 1;

	initial begin
		wait (cycleCount == timeoutCycles);
		$display("Timeout: the DUT did not finish within %0d cycles", timeoutCycles);
		$display("Regression failed");
		$fatal(1, "run aborted on timeout");
	end

	task automatic checkValue(input logic [255:0] actual, input logic [255:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Regression failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// one start pulse that the next edge accepts
	task automatic launchJob(input logic [639:0] hdr, input logic [31:0] firstNonce,
		input logic [31:0] count, input logic [255:0] tgt);
		@(posedge clock);
		header <= hdr;
		startNonce <= firstNonce;
		nonceCount <= count;
		target <= tgt;
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
	endtask

	task automatic waitForDone();
		do
			@(negedge clock);
		while (!done);
	endtask

	task automatic testReset();
		@(negedge clock);
		checkValue(busy, 1'b0, "busy after reset");
		checkValue(done, 1'b0, "done after reset");
		checkValue(found, 1'b0, "found after reset");
	endtask

	task automatic testGenesisHit();
		logic [255:0] displayHash;
		launchJob(genesisHeader, knownNonce - 2, 32'd4, genesisTarget);
		waitForDone();
		displayHash = {<<8{foundHash}};
		checkValue(found, 1'b1, "genesis found");
		checkValue(foundNonce, knownNonce, "genesis nonce");
		checkValue(displayHash, knownHash, "genesis hash");
		@(negedge clock);
		checkValue(busy, 1'b0, "busy after genesis job");
	endtask

	task automatic testRangeMiss();
		logic [31:0] offset;
		offset = $urandom % 1001;
		launchJob(genesisHeader, knownNonce + 1 + offset, 32'd3, genesisTarget);
		waitForDone();
		checkValue(found, 1'b0, "found in a range past the genesis nonce");
	endtask

	task automatic testEasyTarget();
		launchJob(genesisHeader, 32'h0bad_cafe, 32'd3, '1);
		waitForDone();
		checkValue(found, 1'b1, "found with an all-ones target");
		checkValue(foundNonce, 32'h0bad_cafe, "first nonce wins");
	endtask

	task automatic testZeroTarget();
		launchJob(genesisHeader, 32'h1000_0000, 32'd2, '0);
		@(negedge clock);
		checkValue(busy, 1'b1, "busy after start");
		// second start mid-job that would hit at once if taken
		@(posedge clock);
		header <= ~genesisHeader;
		startNonce <= 32'h2000_0000;
		nonceCount <= 32'd1;
		target <= '1;
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		waitForDone();
		checkValue(found, 1'b0, "found with a zero target");
	endtask

	initial begin
		void'($urandom(32'hecba_8741));
		reset = 1'b1;
		start = 1'b0;
		header = '0;
		startNonce = '0;
		nonceCount = '0;
		target = '0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		testReset();
		testGenesisHit();
		testRangeMiss();
		testEasyTarget();
		testZeroTarget();

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire
